// ==== hdl/sad_pkg.sv ====
`default_nettype none

package sad_pkg;

   // sizes
   localparam int SAD_REF_SAMPLES  = 8;
   localparam int SAD_SAMPLE_BITS  = 12;
   localparam int SAD_SUM_BITS     = 15;                   // 8 x 4095 fits
   localparam int SAD_INDEX_BITS   = 16;
   localparam int SAD_BYTECNT_BITS = 7;
   localparam int SAD_REF_BYTES    = 2 * SAD_REF_SAMPLES;  // low byte + high nibble each

   // register map, all registers 8 bits wide on the bus
   localparam logic [7:0] REG_CTRL       = 8'h00;  // wr bit0 arms, rd state code
   localparam logic [7:0] REG_THRESHOLD  = 8'h01;  // two bytes, low first
   localparam logic [7:0] REG_REFERENCE  = 8'h02;  // sample i at bytes 2i, 2i+1
   localparam logic [7:0] REG_TRIG_INDEX = 8'h03;  // read only
   localparam logic [7:0] REG_TRIG_SAD   = 8'h04;  // read only

   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_FILL   = 2'd1,
      ST_SEARCH = 2'd2,
      ST_DONE   = 2'd3
   } sad_state_e;

   typedef logic [SAD_SAMPLE_BITS-1:0] sad_sample_t;
   typedef logic [SAD_SUM_BITS-1:0]    sad_sum_t;
   typedef logic [SAD_INDEX_BITS-1:0]  sad_index_t;

   // entry 0 is the oldest sample, entry 7 the newest
   typedef logic [SAD_REF_SAMPLES-1:0][SAD_SAMPLE_BITS-1:0] sad_ref_array_t;

endpackage

`default_nettype wire

// ==== hdl/sad_reg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sad_reg_if;
   import sad_pkg::*;

   logic [7:0]                  reg_address;  // latched in the address phase
   logic [SAD_BYTECNT_BITS-1:0] reg_bytecnt;  // byte within the register
   logic [7:0]                  reg_wdata;
   logic                        reg_write;    // one cycle
   logic                        reg_read;     // one cycle
   logic [7:0]                  reg_rdata;    // back towards the host

   modport port_side (
      output reg_address, reg_bytecnt, reg_wdata, reg_write, reg_read,
      input  reg_rdata
   );

   modport reg_side (
      input  reg_address, reg_bytecnt, reg_wdata, reg_write, reg_read,
      output reg_rdata
   );

endinterface

`default_nettype wire

// ==== hdl/sad_registers.sv ====
`timescale 1ns/1ps
`default_nettype none

module sad_registers (
   input  wire                       clk_usb,
   input  wire                       rst_n,
   sad_reg_if.reg_side               bus,
   output sad_pkg::sad_sum_t         threshold,
   output sad_pkg::sad_ref_array_t   ref_samples,
   output logic                      arm,
   input  wire sad_pkg::sad_state_e  state,
   input  wire sad_pkg::sad_index_t  trig_index,
   input  wire sad_pkg::sad_sum_t    trig_sad
);
   import sad_pkg::*;

   localparam int REF_IDX_BITS = $clog2(SAD_REF_SAMPLES);

   logic [REF_IDX_BITS-1:0] ref_idx;  // sample addressed by the byte count
   logic                    ref_hi;   // odd byte holds the high nibble
   logic                    in_ref;

   // two-byte registers, low byte first
   function automatic logic [7:0] pick_byte(input logic [15:0] value,
                                            input logic [SAD_BYTECNT_BITS-1:0] cnt);
      logic [7:0] b;
      b = '0;
      if (cnt == SAD_BYTECNT_BITS'(0)) begin
         b = value[7:0];
      end else if (cnt == SAD_BYTECNT_BITS'(1)) begin
         b = value[15:8];
      end
      return b;
   endfunction

   assign ref_idx = bus.reg_bytecnt[REF_IDX_BITS:1];
   assign ref_hi  = bus.reg_bytecnt[0];
   assign in_ref  = bus.reg_bytecnt < SAD_BYTECNT_BITS'(SAD_REF_BYTES);

   always_ff @(posedge clk_usb) begin
      if (bus.reg_write) begin
         case (bus.reg_address)
            REG_THRESHOLD: begin
               if (bus.reg_bytecnt == SAD_BYTECNT_BITS'(0)) begin
                  threshold[7:0] <= bus.reg_wdata;
               end else if (bus.reg_bytecnt == SAD_BYTECNT_BITS'(1)) begin
                  threshold[SAD_SUM_BITS-1:8] <= bus.reg_wdata[SAD_SUM_BITS-9:0];
               end
            end
            REG_REFERENCE: begin
               if (in_ref && ref_hi) begin
                  ref_samples[ref_idx][SAD_SAMPLE_BITS-1:8] <=
                     bus.reg_wdata[SAD_SAMPLE_BITS-9:0];
               end else if (in_ref) begin
                  ref_samples[ref_idx][7:0] <= bus.reg_wdata;
               end
            end
            default: ;  // read-only or unmapped
         endcase
      end
   end

   always_ff @(posedge clk_usb or negedge rst_n) begin
      if (!rst_n) begin
         arm <= 1'b0;
      end else begin
         arm <= bus.reg_write && (bus.reg_address == REG_CTRL) &&
                (bus.reg_bytecnt == '0) && bus.reg_wdata[0];
      end
   end

   // readback mux
   always_comb begin
      bus.reg_rdata = '0;
      case (bus.reg_address)
         REG_CTRL: begin
            if (bus.reg_bytecnt == '0) begin
               bus.reg_rdata = 8'(state);
            end
         end
         REG_THRESHOLD:  bus.reg_rdata = pick_byte(16'(threshold), bus.reg_bytecnt);
         REG_REFERENCE: begin
            if (in_ref) begin
               bus.reg_rdata = ref_hi ? 8'(ref_samples[ref_idx][SAD_SAMPLE_BITS-1:8])
                                      : ref_samples[ref_idx][7:0];
            end
         end
         REG_TRIG_INDEX: bus.reg_rdata = pick_byte(16'(trig_index), bus.reg_bytecnt);
         REG_TRIG_SAD:   bus.reg_rdata = pick_byte(16'(trig_sad), bus.reg_bytecnt);
         default:        bus.reg_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/sad_sample_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sad_sample_counter (
   input  wire                 clk_usb,
   input  wire                 rst_n,
   input  wire                 clear,
   input  wire                 adc_valid,
   output sad_pkg::sad_index_t sample_count,
   output logic                window_full
);
   import sad_pkg::*;

   always_ff @(posedge clk_usb or negedge rst_n) begin
      if (!rst_n) begin
         sample_count <= '0;
      end else if (clear) begin
         sample_count <= '0;
      end else if (adc_valid && (sample_count != '1)) begin
         sample_count <= sample_count + 1'b1;  // saturates at max
      end
   end

   // enough samples since arming to fill the window
   assign window_full = sample_count >= SAD_INDEX_BITS'(SAD_REF_SAMPLES);

endmodule

`default_nettype wire

// ==== hdl/sad_trigger_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module sad_trigger_fsm (
   input  wire                      clk_usb,
   input  wire                      rst_n,
   input  wire                      arm,
   input  wire                      window_full,
   input  wire sad_pkg::sad_index_t sample_count,
   input  wire sad_pkg::sad_sum_t   sad_value,
   input  wire                      sad_match,
   input  wire                      sad_valid,
   input  wire                      armed_and_ready,
   output sad_pkg::sad_state_e      state,
   output logic                     counter_clear,
   output logic                     trigger,
   output sad_pkg::sad_index_t      trig_index,
   output sad_pkg::sad_sum_t        trig_sad
);
   import sad_pkg::*;

   logic fire;

   // arming wins over a match in the same cycle
   assign fire = (state == ST_SEARCH) && sad_valid && sad_match &&
                 armed_and_ready && !arm;

   assign counter_clear = arm;  // count restarts as FILL is entered

   always_ff @(posedge clk_usb or negedge rst_n) begin
      if (!rst_n) begin
         state   <= ST_IDLE;
         trigger <= 1'b0;
      end else begin
         trigger <= fire;  // single shot
         if (arm) begin
            state <= ST_FILL;
         end else begin
            case (state)
               ST_FILL:   if (window_full) state <= ST_SEARCH;
               ST_SEARCH: if (fire) state <= ST_DONE;
               default:   ;  // idle and done wait for arm
            endcase
         end
      end
   end

   always_ff @(posedge clk_usb) begin
      if (fire) begin
         trig_index <= sample_count - 1'b1;  // counter already past this sample
         trig_sad   <= sad_value;
      end
   end

   a_trigger_on_done: assert property (@(posedge clk_usb) disable iff (!rst_n)
      trigger |-> (state == ST_DONE) && ($past(state) == ST_SEARCH));

endmodule

`default_nettype wire

// ==== hdl/sad_trigger_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sad_trigger_top (
   input  wire                       clk_usb,
   input  wire                       rst_n,
   input  wire  [7:0]                usb_addr,
   input  wire  [7:0]                usb_din,
   output wire  [7:0]                usb_dout,
   output wire                       usb_isout,
   input  wire                       usb_cen,
   input  wire                       usb_alen,
   input  wire                       usb_wrn,
   input  wire                       usb_rdn,
   input  wire sad_pkg::sad_sample_t adc_data,
   input  wire                       adc_valid,
   input  wire                       armed_and_ready,
   output wire                       trigger
);
   import sad_pkg::*;

   sad_sum_t       threshold;
   sad_ref_array_t ref_samples;
   logic           arm;
   sad_state_e     state;
   sad_index_t     trig_index;
   sad_sum_t       trig_sad;
   logic           counter_clear;
   sad_index_t     sample_count;
   logic           window_full;
   sad_sum_t       sad_value;
   logic           sad_match;
   logic           sad_valid;

   sad_reg_if reg_bus ();

   usb_reg_port usb_reg_port_inst (
      .clk_usb   (clk_usb),
      .rst_n     (rst_n),
      .usb_addr  (usb_addr),
      .usb_din   (usb_din),
      .usb_cen   (usb_cen),
      .usb_alen  (usb_alen),
      .usb_wrn   (usb_wrn),
      .usb_rdn   (usb_rdn),
      .usb_dout  (usb_dout),
      .usb_isout (usb_isout),
      .bus       (reg_bus)
   );

   sad_registers sad_registers_inst (
      .clk_usb     (clk_usb),
      .rst_n       (rst_n),
      .bus         (reg_bus),
      .threshold   (threshold),
      .ref_samples (ref_samples),
      .arm         (arm),
      .state       (state),
      .trig_index  (trig_index),
      .trig_sad    (trig_sad)
   );

   sad_trigger_fsm sad_trigger_fsm_inst (
      .clk_usb         (clk_usb),
      .rst_n           (rst_n),
      .arm             (arm),
      .window_full     (window_full),
      .sample_count    (sample_count),
      .sad_value       (sad_value),
      .sad_match       (sad_match),
      .sad_valid       (sad_valid),
      .armed_and_ready (armed_and_ready),
      .state           (state),
      .counter_clear   (counter_clear),
      .trigger         (trigger),
      .trig_index      (trig_index),
      .trig_sad        (trig_sad)
   );

   sad_sample_counter sad_sample_counter_inst (
      .clk_usb      (clk_usb),
      .rst_n        (rst_n),
      .clear        (counter_clear),
      .adc_valid    (adc_valid),
      .sample_count (sample_count),
      .window_full  (window_full)
   );

   sad_window_engine sad_window_engine_inst (
      .clk_usb     (clk_usb),
      .rst_n       (rst_n),
      .adc_data    (adc_data),
      .adc_valid   (adc_valid),
      .ref_samples (ref_samples),
      .threshold   (threshold),
      .sad_value   (sad_value),
      .sad_match   (sad_match),
      .sad_valid   (sad_valid)
   );

endmodule

`default_nettype wire

// ==== hdl/sad_window_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module sad_window_engine (
   input  wire                          clk_usb,
   input  wire                          rst_n,
   input  wire sad_pkg::sad_sample_t    adc_data,
   input  wire                          adc_valid,
   input  wire sad_pkg::sad_ref_array_t ref_samples,
   input  wire sad_pkg::sad_sum_t       threshold,
   output sad_pkg::sad_sum_t            sad_value,
   output logic                         sad_match,
   output logic                         sad_valid
);
   import sad_pkg::*;

   sad_ref_array_t window;   // [0] oldest .. [7] newest
   sad_sum_t       sad_sum;
   logic           valid_q;  // window updated last edge

   function automatic sad_sample_t abs_diff(input sad_sample_t a, input sad_sample_t b);
      return (a > b) ? a - b : b - a;
   endfunction

   always_ff @(posedge clk_usb) begin
      if (adc_valid) begin
         window <= {adc_data, window[SAD_REF_SAMPLES-1:1]};  // oldest drops out
      end
   end

   always_comb begin
      sad_sum = '0;
      for (int i = 0; i < SAD_REF_SAMPLES; i++) begin
         sad_sum = sad_sum + SAD_SUM_BITS'(abs_diff(window[i], ref_samples[i]));
      end
   end

   always_ff @(posedge clk_usb or negedge rst_n) begin
      if (!rst_n) begin
         valid_q   <= 1'b0;
         sad_valid <= 1'b0;
      end else begin
         valid_q   <= adc_valid;
         sad_valid <= valid_q;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (valid_q) begin
         sad_value <= sad_sum;
         sad_match <= sad_sum <= threshold;  // match at or below
      end
   end

   // adder tree and compare need the gap between samples
   a_sample_spacing: assert property (@(posedge clk_usb) disable iff (!rst_n)
      adc_valid |=> !adc_valid [*3]);

endmodule

`default_nettype wire

// ==== hdl/usb_reg_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_reg_port (
   input  wire          clk_usb,
   input  wire          rst_n,
   input  wire  [7:0]   usb_addr,
   input  wire  [7:0]   usb_din,
   input  wire          usb_cen,
   input  wire          usb_alen,
   input  wire          usb_wrn,
   input  wire          usb_rdn,
   output logic [7:0]   usb_dout,
   output logic         usb_isout,
   sad_reg_if.port_side bus
);

   logic wrn_q;
   logic rdn_q;
   logic sel;
   logic wr_rise;
   logic rd_fall;
   logic rd_rise;

   assign sel     = ~usb_cen;
   assign wr_rise = usb_wrn & ~wrn_q & sel;   // write ends on wrn rising
   assign rd_fall = ~usb_rdn & rdn_q & sel;
   assign rd_rise = usb_rdn & ~rdn_q & sel;   // read cycle finished

   always_ff @(posedge clk_usb or negedge rst_n) begin
      if (!rst_n) begin
         wrn_q         <= 1'b1;
         rdn_q         <= 1'b1;
         bus.reg_write <= 1'b0;
         bus.reg_read  <= 1'b0;
         usb_isout     <= 1'b0;
      end else begin
         wrn_q         <= usb_wrn;
         rdn_q         <= usb_rdn;
         bus.reg_write <= wr_rise;
         bus.reg_read  <= rd_fall;
         usb_isout     <= ~usb_rdn;  // drive the pins while rdn low
      end
   end

   // address phase restarts the byte count
   always_ff @(posedge clk_usb or negedge rst_n) begin
      if (!rst_n) begin
         bus.reg_address <= '0;
         bus.reg_bytecnt <= '0;
      end else if (!usb_alen && sel) begin
         bus.reg_address <= usb_addr;
         bus.reg_bytecnt <= '0;
      end else if (bus.reg_write || rd_rise) begin
         bus.reg_bytecnt <= bus.reg_bytecnt + 1'b1;  // after the write pulse
      end
   end

   always_ff @(posedge clk_usb) begin
      if (wr_rise) begin
         bus.reg_wdata <= usb_din;
      end
   end

   always_ff @(posedge clk_usb or negedge rst_n) begin
      if (!rst_n) begin
         usb_dout <= '0;
      end else if (bus.reg_read) begin
         usb_dout <= bus.reg_rdata;  // valid two cycles after rdn falls
      end
   end

   a_single_access: assert property (@(posedge clk_usb) disable iff (!rst_n)
      !(bus.reg_write && bus.reg_read));

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
hdl/sad_pkg.sv
hdl/sad_reg_if.sv
hdl/usb_reg_port.sv
hdl/sad_registers.sv
hdl/sad_trigger_fsm.sv
hdl/sad_sample_counter.sv
hdl/sad_window_engine.sv
hdl/sad_trigger_top.sv
test/tb_sad_trigger.sv

// ==== include/tb_sad_tasks.svh ====
`ifndef TB_SAD_TASKS_SVH
`define TB_SAD_TASKS_SVH

// galois lfsr stepped once per bit taken with the newest bit in the lsb
function automatic logic [31:0] lfsr_bits(input int n);
   logic [31:0] r;
   r = '0;
   for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
   end
   return r;
endfunction

// win[0] is the oldest of the last eight samples and pairs with refs[0]
function automatic sad_sum_t model_sad(input sad_sample_t win[$], input sad_ref_array_t refs);
   int sum;
   int d;
   sum = 0;
   for (int i = 0; i < SAD_REF_SAMPLES; i++) begin
      d = int'(win[i]) - int'(refs[i]);
      sum += (d < 0) ? -d : d;
   end
   return sad_sum_t'(sum);
endfunction

task automatic reg_write_bytes(input logic [7:0] addr, input int n);
   usb_addr = addr;
   usb_cen  = 1'b0;
   usb_alen = 1'b0;  // address phase
   @(negedge clk_usb);
   usb_alen = 1'b1;
   for (int i = 0; i < n; i++) begin
      usb_din = wr_buf[i];
      usb_wrn = 1'b0;
      @(negedge clk_usb);
      usb_wrn = 1'b1;  // byte commits on this rising edge
      repeat (3) @(negedge clk_usb);
   end
   usb_cen = 1'b1;
endtask

task automatic reg_read_bytes(input logic [7:0] addr, input int n);
   usb_addr = addr;
   usb_cen  = 1'b0;
   usb_alen = 1'b0;
   @(negedge clk_usb);
   usb_alen = 1'b1;
   for (int i = 0; i < n; i++) begin
      usb_rdn = 1'b0;
      repeat (2) @(negedge clk_usb);  // dout valid two cycles after rdn falls
      rd_buf[i] = usb_dout;
      if (usb_isout !== 1'b1) begin
         fail_count++;
         $display("usb_isout was not high during a read of address %h at %0t", addr, $time);
      end
      usb_rdn = 1'b1;  // next byte
      @(negedge clk_usb);
   end
   usb_cen = 1'b1;
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
   if (got !== want) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
   end
endtask

task automatic check_sum(input string name, input sad_sum_t got, input sad_sum_t want);
   if (got !== want) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
   end
endtask

task automatic check_index(input string name, input sad_index_t got, input sad_index_t want);
   if (got !== want) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
   end
endtask

task automatic check_state(input string name, input sad_state_e got, input sad_state_e want);
   if (got !== want) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s got %0d expected %s", $time, name, got, want.name());
   end
endtask

task automatic check_trigger(input string name, input logic got, input bit want);
   if (got !== want) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, want);
   end
endtask

`endif

// ==== test/tb_sad_trigger.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sad_trigger;
   import sad_pkg::*;

   localparam int CLK_PERIOD       = 10;
   localparam int NUM_SAMPLES      = 71;
   localparam int NUM_BUS_BYTES    = 63;
   localparam int NUM_BUS_ACCESSES = 24;
   localparam int WATCHDOG_CYCLES  = 2 * (NUM_SAMPLES * 5 + NUM_BUS_BYTES * 4 +
                                          NUM_BUS_ACCESSES * 3) + 10;

   logic        clk_usb;
   logic        rst_n;
   logic [7:0]  usb_addr;
   logic [7:0]  usb_din;
   wire  [7:0]  usb_dout;
   wire         usb_isout;
   logic        usb_cen;
   logic        usb_alen;
   logic        usb_wrn;
   logic        usb_rdn;
   sad_sample_t adc_data;
   logic        adc_valid;
   logic        armed_and_ready;
   wire         trigger;

   logic [31:0]    lfsr_q = 32'hb74abf5b;
   logic [7:0]     wr_buf [16];
   logic [7:0]     rd_buf [16];
   int             mismatch_count = 0;
   int             fail_count = 0;
   sad_ref_array_t ref_model;          // reference as the host wrote it
   sad_sum_t       thr_model;
   sad_sample_t    hist[$];            // last eight samples with the oldest first
   int             since_arm = 0;
   sad_state_e     model_state = ST_IDLE;
   sad_index_t     exp_index;

   `include "tb_sad_tasks.svh"

   sad_trigger_top sad_trigger_top_inst (
      .clk_usb(clk_usb), .rst_n(rst_n),
      .usb_addr(usb_addr), .usb_din(usb_din), .usb_dout(usb_dout), .usb_isout(usb_isout),
      .usb_cen(usb_cen), .usb_alen(usb_alen), .usb_wrn(usb_wrn), .usb_rdn(usb_rdn),
      .adc_data(adc_data), .adc_valid(adc_valid), .armed_and_ready(armed_and_ready),
      .trigger(trigger)
   );

   initial begin
      clk_usb = 1'b0;
      forever #(CLK_PERIOD / 2) clk_usb = ~clk_usb;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   task automatic write_threshold(input sad_sum_t t);
      wr_buf[0] = t[7:0];
      wr_buf[1] = 8'(t[SAD_SUM_BITS-1:8]);
      reg_write_bytes(REG_THRESHOLD, 2);
      thr_model = t;
   endtask

   task automatic arm_trigger();
      wr_buf[0] = 8'h01;
      reg_write_bytes(REG_CTRL, 1);
      model_state = ST_FILL;  // any state rearms
      since_arm   = 0;
   endtask

   task automatic expect_state(input sad_state_e want);
      reg_read_bytes(REG_CTRL, 1);
      check_state("state", sad_state_e'(rd_buf[0][1:0]), want);
   endtask

   // trigger must show only in the cycle after the second edge past acceptance
   task automatic send_sample(input sad_sample_t s);
      bit       fire;
      sad_sum_t sad;
      fire = 1'b0;
      hist.push_back(s);
      if (hist.size() > SAD_REF_SAMPLES) begin
         void'(hist.pop_front());
      end
      since_arm++;
      if (model_state == ST_FILL && since_arm >= SAD_REF_SAMPLES) begin
         model_state = ST_SEARCH;
      end
      if (model_state == ST_SEARCH) begin
         sad = model_sad(hist, ref_model);
         if (armed_and_ready && sad <= thr_model) begin
            fire        = 1'b1;
            model_state = ST_DONE;
            exp_index   = sad_index_t'(since_arm - 1);
         end
      end
      adc_data  = s;
      adc_valid = 1'b1;
      for (int k = 1; k <= 5; k++) begin
         @(negedge clk_usb);
         adc_valid = 1'b0;
         check_trigger("trigger", trigger, fire && (k == 3));
      end
   endtask

   task automatic send_random(input int n);
      repeat (n) send_sample(sad_sample_t'(lfsr_bits(SAD_SAMPLE_BITS)));
   endtask

   task automatic send_pattern(input sad_ref_array_t p, input int first, input int last);
      for (int i = first; i <= last; i++) begin
         send_sample(p[i]);
      end
   endtask

   task automatic test_reset_and_regs();
      sad_sum_t t;
      check_trigger("trigger", trigger, 1'b0);
      expect_state(ST_IDLE);
      t = sad_sum_t'(lfsr_bits(SAD_SUM_BITS));
      write_threshold(t);
      reg_read_bytes(REG_THRESHOLD, 2);
      check_byte("threshold[7:0]", rd_buf[0], t[7:0]);
      check_byte("threshold[15:8]", rd_buf[1], 8'(t[SAD_SUM_BITS-1:8]));
      for (int i = 0; i < 16; i++) begin
         wr_buf[i] = 8'(lfsr_bits(8));  // high nibbles get junk too
      end
      reg_write_bytes(REG_REFERENCE, 16);
      for (int i = 0; i < SAD_REF_SAMPLES; i++) begin
         ref_model[i] = {wr_buf[2*i+1][3:0], wr_buf[2*i]};
      end
      reg_read_bytes(REG_REFERENCE, 16);
      for (int i = 0; i < 16; i++) begin
         check_byte($sformatf("reference byte %0d", i), rd_buf[i],
                    (i % 2) ? (wr_buf[i] & 8'h0f) : wr_buf[i]);
      end
   endtask

   task automatic test_exact_match();
      write_threshold('0);
      arm_trigger();
      send_random(5);
      send_pattern(ref_model, 0, SAD_REF_SAMPLES - 1);
      send_random(3);  // no second pulse
      reg_read_bytes(REG_TRIG_INDEX, 2);
      check_index("trig_index", {rd_buf[1], rd_buf[0]}, exp_index);
      reg_read_bytes(REG_TRIG_SAD, 2);
      check_sum("trig_sad", sad_sum_t'({rd_buf[1], rd_buf[0]}), '0);
      expect_state(ST_DONE);
   endtask

   task automatic test_threshold_edge();
      sad_ref_array_t pert;
      sad_sample_t    delta;
      sad_sample_t    q[$];
      sad_sum_t       s;
      for (int i = 0; i < SAD_REF_SAMPLES; i++) begin
         delta   = sad_sample_t'(lfsr_bits(4)) | sad_sample_t'(i == 0);  // S at least 1
         pert[i] = ref_model[i][SAD_SAMPLE_BITS-1] ? ref_model[i] - delta
                                                   : ref_model[i] + delta;
         q.push_back(pert[i]);
      end
      s = model_sad(q, ref_model);
      write_threshold(s - 1'b1);
      arm_trigger();
      send_pattern(pert, 0, SAD_REF_SAMPLES - 1);
      send_random(2);
      expect_state(ST_SEARCH);
      write_threshold(s);
      arm_trigger();
      send_pattern(pert, 0, SAD_REF_SAMPLES - 1);
      reg_read_bytes(REG_TRIG_SAD, 2);
      check_sum("trig_sad", sad_sum_t'({rd_buf[1], rd_buf[0]}), s);
      expect_state(ST_DONE);
   endtask

   task automatic test_ready_gate();
      write_threshold('0);
      arm_trigger();
      armed_and_ready = 1'b0;
      send_random(3);
      send_pattern(ref_model, 0, SAD_REF_SAMPLES - 1);
      expect_state(ST_SEARCH);
      armed_and_ready = 1'b1;
      send_random(2);
      send_pattern(ref_model, 0, SAD_REF_SAMPLES - 1);
      expect_state(ST_DONE);
   endtask

   task automatic test_single_shot();
      send_pattern(ref_model, 0, SAD_REF_SAMPLES - 1);  // matches yet already fired
      send_sample(ref_model[0]);
      expect_state(ST_DONE);
      arm_trigger();
      // window equals the reference after only seven samples since arming
      send_pattern(ref_model, 1, SAD_REF_SAMPLES - 1);
      expect_state(ST_FILL);
   endtask

   initial begin
      rst_n           = 1'b0;
      usb_addr        = '0;
      usb_din         = '0;
      usb_cen         = 1'b1;
      usb_alen        = 1'b1;
      usb_wrn         = 1'b1;
      usb_rdn         = 1'b1;
      adc_data        = '0;
      adc_valid       = 1'b0;
      armed_and_ready = 1'b1;
      repeat (2) @(negedge clk_usb);
      rst_n = 1'b1;
      @(negedge clk_usb);
      test_reset_and_regs();
      test_exact_match();
      test_threshold_edge();
      test_ready_gate();
      test_single_shot();
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
      if (mismatch_count == 0 && fail_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
